// File: rtl/hilo_pkg.sv
package hilo_pkg;

    // data path widths
    localparam int word_width = 32;

    typedef logic [word_width-1:0]   word_t;
    typedef logic [2*word_width-1:0] dword_t;

    // HI/LO operation carried by each issue lane
    // codes 6 and 7 are unused and decode as no operation
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_MTHI = 3'd1,
        OP_MTLO = 3'd2,
        OP_MULT = 3'd3,
        OP_MADD = 3'd4,
        OP_MSUB = 3'd5
    } hilo_op_e;

    // how a lane's operand combines with the held HI/LO pair
    typedef enum logic [1:0] {
        ACC_NONE = 2'd0,
        ACC_ADD  = 2'd1,
        ACC_SUB  = 2'd2
    } acc_mode_e;

    // split view, hi is the upper word
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_half_t;

    // one 64-bit value seen either whole or as its two halves
    typedef union packed {
        dword_t     whole;
        hilo_half_t half;
    } hilo_word_u;

    // register contents after reset
    localparam word_t reset_hi = '0;
    localparam word_t reset_lo = '0;

endpackage

// File: rtl/hilo_lane_decode.sv
`timescale 1ns/100ps

module hilo_lane_decode (
    input  hilo_pkg::hilo_op_e   i_op,
    input  hilo_pkg::word_t      i_src,
    input  hilo_pkg::dword_t     i_prod,
    output logic                 o_write_hi,
    output logic                 o_write_lo,
    output hilo_pkg::acc_mode_e  o_mode,
    output hilo_pkg::hilo_word_u o_operand
);
    import hilo_pkg::*;

    // purely combinational, one instance per issue lane
    always_comb begin
        o_write_hi = 1'b0;
        o_write_lo = 1'b0;
        o_mode     = ACC_NONE;
        o_operand  = '0;

        case (i_op)
            // moves only touch their own half
            OP_MTHI: begin
                o_operand.half.hi = i_src;
                o_write_hi        = 1'b1;
            end

            OP_MTLO: begin
                o_operand.half.lo = i_src;
                o_write_lo        = 1'b1;
            end

            // full product replaces the pair
            OP_MULT: begin
                o_operand.whole = i_prod;
                o_write_hi      = 1'b1;
                o_write_lo      = 1'b1;
            end

            // accumulate forms keep the product whole so the
            // merge stage can carry across the LO/HI boundary
            OP_MADD: begin
                o_operand.whole = i_prod;
                o_write_hi      = 1'b1;
                o_write_lo      = 1'b1;
                o_mode          = ACC_ADD;
            end

            OP_MSUB: begin
                o_operand.whole = i_prod;
                o_write_hi      = 1'b1;
                o_write_lo      = 1'b1;
                o_mode          = ACC_SUB;
            end

            // OP_NONE and unused codes write nothing
            default: begin
                o_write_hi = 1'b0;
                o_write_lo = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/hilo_merge.sv
`timescale 1ns/100ps

module hilo_merge (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_valid,
    input  logic                 i_write_hi1,
    input  logic                 i_write_lo1,
    input  hilo_pkg::acc_mode_e  i_mode1,
    input  hilo_pkg::hilo_word_u i_operand1,
    input  logic                 i_write_hi0,
    input  logic                 i_write_lo0,
    input  hilo_pkg::acc_mode_e  i_mode0,
    input  hilo_pkg::hilo_word_u i_operand0,
    input  logic                 i_ready,
    output logic                 o_ready,
    output logic                 o_valid,
    output hilo_pkg::word_t      o_hi,
    output hilo_pkg::word_t      o_lo
);
    import hilo_pkg::*;

    // stage register, holds one decoded pair
    logic       stage_valid;
    logic       stage_write_hi1;
    logic       stage_write_lo1;
    acc_mode_e  stage_mode1;
    hilo_word_u stage_operand1;
    logic       stage_write_hi0;
    logic       stage_write_lo0;
    acc_mode_e  stage_mode0;
    hilo_word_u stage_operand0;

    // architectural HI/LO, also the output payload
    word_t      hi_q;
    word_t      lo_q;
    logic       out_valid;

    hilo_word_u current;
    hilo_word_u cand1;
    hilo_word_u cand0;
    word_t      new_hi;
    word_t      new_lo;
    logic       accept;
    logic       advance;

    // value a single lane would leave in HI/LO on its own
    function automatic hilo_word_u lane_candidate(
        input acc_mode_e  mode,
        input hilo_word_u operand,
        input hilo_word_u held
    );
        hilo_word_u result;
        case (mode)
            ACC_ADD: result.whole = held.whole + operand.whole;
            ACC_SUB: result.whole = held.whole - operand.whole;
            default: result.whole = operand.whole;
        endcase
        return result;
    endfunction

    // handshake
    // stage moves on when the output slot is free or being drained
    assign advance = stage_valid && (!out_valid || i_ready);
    assign o_ready = !stage_valid || advance;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (advance) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_write_hi1 <= i_write_hi1;
            stage_write_lo1 <= i_write_lo1;
            stage_mode1     <= i_mode1;
            stage_operand1  <= i_operand1;
            stage_write_hi0 <= i_write_hi0;
            stage_write_lo0 <= i_write_lo0;
            stage_mode0     <= i_mode0;
            stage_operand0  <= i_operand0;
        end
    end

    // both lanes accumulate against the pair held before this bundle
    assign current.half.hi = hi_q;
    assign current.half.lo = lo_q;

    assign cand1 = lane_candidate(stage_mode1, stage_operand1, current);
    assign cand0 = lane_candidate(stage_mode0, stage_operand0, current);

    // lane 0 is younger, so it takes priority per half
    always_comb begin
        if (stage_write_hi0) begin
            new_hi = cand0.half.hi;
        end else if (stage_write_hi1) begin
            new_hi = cand1.half.hi;
        end else begin
            new_hi = hi_q;
        end

        if (stage_write_lo0) begin
            new_lo = cand0.half.lo;
        end else if (stage_write_lo1) begin
            new_lo = cand1.half.lo;
        end else begin
            new_lo = lo_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= reset_hi;
            lo_q <= reset_lo;
        end else if (advance) begin
            hi_q <= new_hi;
            lo_q <= new_lo;
        end
    end

    // output slot; HI/LO only change on advance, so they stay
    // stable while a result waits for i_ready
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= 1'b1;
        end else if (i_ready) begin
            out_valid <= 1'b0;
        end
    end

    assign o_valid = out_valid;
    assign o_hi    = hi_q;
    assign o_lo    = lo_q;

endmodule

// File: rtl/hilo_unit.sv
`timescale 1ns/100ps

module hilo_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_valid,
    input  hilo_pkg::hilo_op_e i_op1,
    input  hilo_pkg::word_t    i_src1,
    input  hilo_pkg::dword_t   i_prod1,
    input  hilo_pkg::hilo_op_e i_op0,
    input  hilo_pkg::word_t    i_src0,
    input  hilo_pkg::dword_t   i_prod0,
    input  logic               i_ready,
    output logic               o_ready,
    output logic               o_valid,
    output hilo_pkg::word_t    o_hi,
    output hilo_pkg::word_t    o_lo
);
    import hilo_pkg::*;

    // decoded lane 1, the older instruction
    logic       lane1_write_hi;
    logic       lane1_write_lo;
    acc_mode_e  lane1_mode;
    hilo_word_u lane1_operand;

    // decoded lane 0, the younger instruction
    logic       lane0_write_hi;
    logic       lane0_write_lo;
    acc_mode_e  lane0_mode;
    hilo_word_u lane0_operand;

    hilo_lane_decode lane1_decode (
        .i_op       (i_op1),
        .i_src      (i_src1),
        .i_prod     (i_prod1),
        .o_write_hi (lane1_write_hi),
        .o_write_lo (lane1_write_lo),
        .o_mode     (lane1_mode),
        .o_operand  (lane1_operand)
    );

    hilo_lane_decode lane0_decode (
        .i_op       (i_op0),
        .i_src      (i_src0),
        .i_prod     (i_prod0),
        .o_write_hi (lane0_write_hi),
        .o_write_lo (lane0_write_lo),
        .o_mode     (lane0_mode),
        .o_operand  (lane0_operand)
    );

    // stage register, HI/LO registers and both handshakes
    hilo_merge merge (
        .clk         (clk),
        .reset       (reset),
        .i_valid     (i_valid),
        .i_write_hi1 (lane1_write_hi),
        .i_write_lo1 (lane1_write_lo),
        .i_mode1     (lane1_mode),
        .i_operand1  (lane1_operand),
        .i_write_hi0 (lane0_write_hi),
        .i_write_lo0 (lane0_write_lo),
        .i_mode0     (lane0_mode),
        .i_operand0  (lane0_operand),
        .i_ready     (i_ready),
        .o_ready     (o_ready),
        .o_valid     (o_valid),
        .o_hi        (o_hi),
        .o_lo        (o_lo)
    );

endmodule

// File: verif/hilo_unit_checker.sv
`timescale 1ns/100ps

module hilo_unit_checker (
    input logic               clk,
    input logic               reset,
    input logic               i_valid,
    input hilo_pkg::hilo_op_e i_op1,
    input hilo_pkg::word_t    i_src1,
    input hilo_pkg::dword_t   i_prod1,
    input hilo_pkg::hilo_op_e i_op0,
    input hilo_pkg::word_t    i_src0,
    input hilo_pkg::dword_t   i_prod0,
    input logic               i_ready,
    input logic               o_ready,
    input logic               o_valid,
    input hilo_pkg::word_t    o_hi,
    input hilo_pkg::word_t    o_lo
);

    // no result may be offered straight out of reset
    assert property (@(posedge clk) reset |=> !o_valid)
        else $error("o_valid high after a reset cycle");

    // a stalled result keeps its payload
    assert property (@(posedge clk) disable iff (reset)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_hi) && $stable(o_lo)))
        else $error("output changed while waiting for i_ready");

    // an offered pair holds until accepted
    assert property (@(posedge clk) disable iff (reset)
        (i_valid && !o_ready) |=> (i_valid && $stable(i_op1) && $stable(i_src1)
            && $stable(i_prod1) && $stable(i_op0) && $stable(i_src0)
            && $stable(i_prod0)))
        else $error("input pair changed before it was accepted");

endmodule

bind hilo_unit hilo_unit_checker checker_inst (
    .clk     (clk),
    .reset   (reset),
    .i_valid (i_valid),
    .i_op1   (i_op1),
    .i_src1  (i_src1),
    .i_prod1 (i_prod1),
    .i_op0   (i_op0),
    .i_src0  (i_src0),
    .i_prod0 (i_prod0),
    .i_ready (i_ready),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_hi    (o_hi),
    .o_lo    (o_lo)
);

// File: verif/hilo_unit_tb.sv
`timescale 1ns/100ps

module hilo_unit_tb;
    import hilo_pkg::*;

    localparam int num_directed = 12;
    localparam int num_random   = 2000;
    localparam int cycle_limit  = 20 * (num_directed + num_random);
    localparam logic [31:0] lfsr_seed = 32'hdd51e85b;

    logic     clk = 1'b0;
    logic     reset;
    logic     i_valid;
    hilo_op_e i_op1;
    word_t    i_src1;
    dword_t   i_prod1;
    hilo_op_e i_op0;
    word_t    i_src0;
    dword_t   i_prod0;
    logic     i_ready;
    logic     o_ready;
    logic     o_valid;
    word_t    o_hi;
    word_t    o_lo;

    // reference HI/LO and the results still owed by the DUT
    word_t       m_hi;
    word_t       m_lo;
    word_t       exp_hi_q[$];
    word_t       exp_lo_q[$];
    int          acc_cycle_q[$];
    logic [31:0] lfsr_state = lfsr_seed;
    logic        track_latency;
    logic        took;
    int          cycle_count  = 0;
    int          accept_count = 0;
    int          result_count = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    hilo_unit uut (
        .clk     (clk),
        .reset   (reset),
        .i_valid (i_valid),
        .i_op1   (i_op1),
        .i_src1  (i_src1),
        .i_prod1 (i_prod1),
        .i_op0   (i_op0),
        .i_src0  (i_src0),
        .i_prod0 (i_prod0),
        .i_ready (i_ready),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .o_hi    (o_hi),
        .o_lo    (o_lo)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    // effect of one lane taken alone on the held pair
    task automatic model_lane(input hilo_op_e op, input word_t src, input dword_t prod,
                              input dword_t held, output logic wr_hi, output logic wr_lo,
                              output dword_t val);
        wr_hi = 1'b0;
        wr_lo = 1'b0;
        val   = held;
        case (op)
            OP_MTHI: begin
                wr_hi      = 1'b1;
                val[63:32] = src;
            end
            OP_MTLO: begin
                wr_lo     = 1'b1;
                val[31:0] = src;
            end
            OP_MULT: begin
                wr_hi = 1'b1;
                wr_lo = 1'b1;
                val   = prod;
            end
            OP_MADD: begin
                wr_hi = 1'b1;
                wr_lo = 1'b1;
                val   = held + prod;
            end
            OP_MSUB: begin
                wr_hi = 1'b1;
                wr_lo = 1'b1;
                val   = held - prod;
            end
            default: val = held;
        endcase
    endtask

    task automatic model_pair(input hilo_op_e op1, input word_t src1, input dword_t prod1,
                              input hilo_op_e op0, input word_t src0, input dword_t prod0);
        dword_t held;
        dword_t v1;
        dword_t v0;
        logic   wh1;
        logic   wl1;
        logic   wh0;
        logic   wl0;
        held = {m_hi, m_lo};
        model_lane(op1, src1, prod1, held, wh1, wl1, v1);
        model_lane(op0, src0, prod0, held, wh0, wl0, v0);
        // younger lane 0 overrides older lane 1 per half
        if (wh0) m_hi = v0[63:32];
        else if (wh1) m_hi = v1[63:32];
        if (wl0) m_lo = v0[31:0];
        else if (wl1) m_lo = v1[31:0];
        exp_hi_q.push_back(m_hi);
        exp_lo_q.push_back(m_lo);
        acc_cycle_q.push_back(track_latency ? cycle_count : -1);
    endtask

    // one clock edge; values read here are those before the edge
    task automatic tick();
        word_t exp_hi;
        word_t exp_lo;
        int    acc_cycle;
        @(posedge clk);
        took = i_valid && o_ready;
        if (o_valid && i_ready) begin
            result_count++;
            assert (exp_hi_q.size() != 0) else begin
                other_errors++;
                $display("a result came out with no accepted pair outstanding");
            end
            if (exp_hi_q.size() != 0) begin
                exp_hi    = exp_hi_q.pop_front();
                exp_lo    = exp_lo_q.pop_front();
                acc_cycle = acc_cycle_q.pop_front();
                assert (o_hi == exp_hi && o_lo == exp_lo) else begin
                    value_errors++;
                    $display("error at %0t: result %0d expected hi=%h lo=%h, got hi=%h lo=%h",
                             $time, result_count, exp_hi, exp_lo, o_hi, o_lo);
                end
                assert (acc_cycle < 0 || cycle_count - acc_cycle == 2) else begin
                    value_errors++;
                    $display("error at %0t: result %0d latency %0d edges, expected 2",
                             $time, result_count, cycle_count - acc_cycle);
                end
            end
        end
        if (took) begin
            accept_count++;
            model_pair(i_op1, i_src1, i_prod1, i_op0, i_src0, i_prod0);
        end
    endtask

    task automatic send_pair(input hilo_op_e op1, input word_t src1, input dword_t prod1,
                             input hilo_op_e op0, input word_t src0, input dword_t prod0);
        int waited;
        i_op1   <= op1;
        i_src1  <= src1;
        i_prod1 <= prod1;
        i_op0   <= op0;
        i_src0  <= src0;
        i_prod0 <= prod0;
        i_valid <= 1'b1;
        took   = 1'b0;
        waited = 0;
        while (!took) begin
            tick();
            waited++;
        end
        // without back-pressure every pair goes in on its first edge
        assert (waited == 1) else begin
            value_errors++;
            $display("error at %0t: pair taken after %0d edges, expected 1", $time, waited);
        end
    endtask

    task automatic random_pair();
        logic [63:0] r;
        take_bits(3, r);
        i_op1 <= hilo_op_e'(r[2:0]);
        take_bits(32, r);
        i_src1 <= r[31:0];
        take_bits(64, r);
        i_prod1 <= r;
        take_bits(3, r);
        i_op0 <= hilo_op_e'(r[2:0]);
        take_bits(32, r);
        i_src0 <= r[31:0];
        take_bits(64, r);
        i_prod0 <= r;
    endtask

    task automatic drain();
        i_ready <= 1'b1;
        while (exp_hi_q.size() != 0) tick();
        // a few idle edges so a repeated or stray result is still seen
        repeat (4) tick();
    endtask

    initial begin
        logic [63:0] r;
        int          offered;
        reset   = 1'b1;
        i_valid = 1'b0;
        i_op1   = OP_NONE;
        i_src1  = '0;
        i_prod1 = '0;
        i_op0   = OP_NONE;
        i_src0  = '0;
        i_prod0 = '0;
        i_ready = 1'b1;
        m_hi    = reset_hi;
        m_lo    = reset_lo;
        track_latency = 1'b1;
        offered = 0;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        tick();
        assert (!o_valid && o_ready) else begin
            other_errors++;
            $display("after reset o_valid was not low or o_ready was not high");
        end

        // directed pairs back to back with no back-pressure
        send_pair(OP_MTHI, 32'ha5a5_0001, 64'h0, OP_NONE, 32'h0, 64'h0);
        send_pair(OP_NONE, 32'h0, 64'h0, OP_NONE, 32'h0, 64'h0);
        send_pair(OP_NONE, 32'h0, 64'h0, OP_MTLO, 32'h0000_beef, 64'h0);
        send_pair(OP_MTLO, 32'h1111_2222, 64'h0, OP_NONE, 32'h0, 64'h0);
        send_pair(OP_MULT, 32'h0, 64'h0000_0001_ffff_fff0, OP_NONE, 32'h0, 64'h0);
        // carry from LO into HI and then a borrow back
        send_pair(OP_MADD, 32'h0, 64'h20, OP_NONE, 32'h0, 64'h0);
        send_pair(OP_MSUB, 32'h0, 64'h40, OP_NONE, 32'h0, 64'h0);
        send_pair(OP_MTHI, 32'h1234_5678, 64'h0, OP_MTHI, 32'h8765_4321, 64'h0);
        send_pair(OP_MADD, 32'h0, 64'h1, OP_MSUB, 32'h0, 64'h0000_0000_ffff_ffff);
        send_pair(OP_MULT, 32'h0, 64'hdead_beef_cafe_f00d, OP_MTLO, 32'h0bad_f00d, 64'h0);
        send_pair(hilo_op_e'(3'd6), 32'hffff_ffff, 64'h1, hilo_op_e'(3'd7), 32'h1, 64'h2);
        send_pair(OP_MTLO, 32'h5555_aaaa, 64'h0, OP_MTHI, 32'haaaa_5555, 64'h0);
        i_valid <= 1'b0;
        drain();

        // random pairs under random back-pressure
        track_latency = 1'b0;
        took = 1'b0;
        while (accept_count < num_directed + num_random) begin
            if (!i_valid || took) begin
                take_bits(4, r);
                if (offered < num_random && r[3:0] >= 4'd4) begin
                    random_pair();
                    i_valid <= 1'b1;
                    offered++;
                end else begin
                    i_valid <= 1'b0;
                end
            end
            take_bits(4, r);
            i_ready <= (r[3:0] >= 4'd5);
            tick();
        end
        i_valid <= 1'b0;
        drain();

        assert (result_count == accept_count) else begin
            other_errors++;
            $display("%0d results came out for %0d accepted pairs", result_count, accept_count);
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/hilo_pkg.sv
rtl/hilo_lane_decode.sv
rtl/hilo_merge.sv
rtl/hilo_unit.sv
verif/hilo_unit_checker.sv
verif/hilo_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the HI/LO writeback testbench with Verilator.
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module hilo_unit_tb \
    -f verilog.f \
    -o hilo_unit_sim

./obj_dir/hilo_unit_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without a reported failure"
exit 0
